// ==== source/ebpf_exe_pkg.sv ====
`default_nettype none

package ebpf_exe_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] imm_t;
  typedef logic [15:0] offset_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [7:0]  byte_sel_t;

  // Opcode bit 3 is clear for the K form.
  localparam int SRC_REG_BIT = 3;

  // Opcode bits 2:0.
  typedef enum logic [2:0] {
    CLASS_OTHER = 3'h0,
    CLASS_STX   = 3'h3,
    CLASS_ALU32 = 3'h4,
    CLASS_ALU64 = 3'h7
  } insn_class_e;

  // Opcode bits 7:4. MUL, DIV, MOD and END have no entry.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_OR   = 4'h4,
    ALU_AND  = 4'h5,
    ALU_LSH  = 4'h6,
    ALU_RSH  = 4'h7,
    ALU_NEG  = 4'h8,
    ALU_XOR  = 4'ha,
    ALU_MOV  = 4'hb,
    ALU_ARSH = 4'hc
  } alu_op_e;

  // Opcode bits 4:3 of a store.
  typedef enum logic [1:0] {
    SIZE_W  = 2'h0,
    SIZE_H  = 2'h1,
    SIZE_B  = 2'h2,
    SIZE_DW = 2'h3
  } store_size_e;

  typedef enum logic {
    BUS_IDLE = 1'b0,
    BUS_WAIT = 1'b1
  } bus_state_e;

endpackage

`default_nettype wire

// ==== source/insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        issue_valid,
  output logic                        issue_ready,
  input  ebpf_exe_pkg::opcode_t       opcode,
  input  ebpf_exe_pkg::reg_addr_t     dst_addr,
  input  ebpf_exe_pkg::reg_addr_t     src_addr,
  input  ebpf_exe_pkg::xlen_t         dst_operand,
  input  ebpf_exe_pkg::xlen_t         src_operand,
  input  ebpf_exe_pkg::imm_t          imm,
  input  ebpf_exe_pkg::offset_t       offset,
  input  logic                        stall,
  output logic                        dec_valid,
  output ebpf_exe_pkg::insn_class_e   insn_class,
  output ebpf_exe_pkg::alu_op_e       alu_op,
  output logic                        use_imm,
  output ebpf_exe_pkg::store_size_e   store_size,
  output ebpf_exe_pkg::reg_addr_t     dec_dst_addr,
  output ebpf_exe_pkg::reg_addr_t     dec_src_addr,
  output ebpf_exe_pkg::xlen_t         dec_dst,
  output ebpf_exe_pkg::xlen_t         dec_src,
  output ebpf_exe_pkg::imm_t          dec_imm,
  output ebpf_exe_pkg::offset_t       dec_offset
);

  import ebpf_exe_pkg::*;

  logic        accept;
  insn_class_e class_next;

  assign issue_ready = !stall;
  assign accept      = issue_valid && issue_ready;

  // Loads and immediate stores fall into the other class.
  always_comb begin
    case (opcode[2:0])
      CLASS_ALU32: class_next = CLASS_ALU32;
      CLASS_ALU64: class_next = CLASS_ALU64;
      CLASS_STX:   class_next = CLASS_STX;
      default:     class_next = CLASS_OTHER;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (!stall) begin
      dec_valid <= accept; // Empty slot when nothing is offered.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      insn_class   <= class_next;
      alu_op       <= alu_op_e'(opcode[7:4]);
      use_imm      <= !opcode[SRC_REG_BIT];
      store_size   <= store_size_e'(opcode[4:3]);
      dec_dst_addr <= dst_addr;
      dec_src_addr <= src_addr;
      dec_dst      <= dst_operand;
      dec_src      <= src_operand;
      dec_imm      <= imm;
      dec_offset   <= offset;
    end
  end

  // The held instruction must survive a whole bus cycle.
  a_hold_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable(dec_valid) && $stable(dec_dst) && $stable(dec_src));

endmodule

`default_nettype wire

// ==== source/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_core (
  input  ebpf_exe_pkg::insn_class_e insn_class,
  input  ebpf_exe_pkg::alu_op_e     alu_op,
  input  logic                      use_imm,
  input  ebpf_exe_pkg::xlen_t       op_a,
  input  ebpf_exe_pkg::xlen_t       op_b,
  input  ebpf_exe_pkg::imm_t        imm,
  output ebpf_exe_pkg::xlen_t       alu_result
);

  import ebpf_exe_pkg::*;

  logic       is_32;
  xlen_t      operand_b;
  xlen_t      a_zx;
  xlen_t      a_sx;
  xlen_t      b_ext;
  xlen_t      raw;
  logic [5:0] shamt;

  assign is_32     = (insn_class == CLASS_ALU32);
  assign operand_b = use_imm ? {32'b0, imm} : op_b;

  // In 32-bit mode the upper half is cleared, except for ARSH which needs bit 31.
  assign a_zx  = is_32 ? {32'b0, op_a[31:0]} : op_a;
  assign a_sx  = is_32 ? {{32{op_a[31]}}, op_a[31:0]} : op_a;
  assign b_ext = is_32 ? {32'b0, operand_b[31:0]} : operand_b;
  assign shamt = is_32 ? {1'b0, operand_b[4:0]} : operand_b[5:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  raw = a_zx + b_ext;
      ALU_SUB:  raw = a_zx - b_ext;
      ALU_OR:   raw = a_zx | b_ext;
      ALU_AND:  raw = a_zx & b_ext;
      ALU_LSH:  raw = a_zx << shamt;
      ALU_RSH:  raw = a_zx >> shamt;
      ALU_NEG:  raw = -a_zx;
      ALU_XOR:  raw = a_zx ^ b_ext;
      ALU_MOV:  raw = b_ext;
      ALU_ARSH: raw = $signed(a_sx) >>> shamt;
      default:  raw = a_zx; // Destination written back unchanged.
    endcase
  end

  assign alu_result = is_32 ? {32'b0, raw[31:0]} : raw;

endmodule

`default_nettype wire

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      dec_valid,
  input  ebpf_exe_pkg::insn_class_e insn_class,
  input  ebpf_exe_pkg::alu_op_e     alu_op,
  input  logic                      use_imm,
  input  ebpf_exe_pkg::imm_t        dec_imm,
  input  ebpf_exe_pkg::reg_addr_t   dec_dst_addr,
  input  ebpf_exe_pkg::reg_addr_t   dec_src_addr,
  input  ebpf_exe_pkg::xlen_t       dec_dst,
  input  ebpf_exe_pkg::xlen_t       dec_src,
  input  logic                      stall,
  output ebpf_exe_pkg::xlen_t       fwd_dst,
  output ebpf_exe_pkg::xlen_t       fwd_src,
  output logic                      rf_we,
  output ebpf_exe_pkg::reg_addr_t   rf_addr,
  output ebpf_exe_pkg::xlen_t       rf_data
);

  import ebpf_exe_pkg::*;

  logic      res_valid;
  reg_addr_t res_addr;
  xlen_t     res_data;
  xlen_t     alu_result;
  logic      alu_exec;

  // The result register is always the newest register write.
  assign fwd_dst = (res_valid && res_addr == dec_dst_addr) ? res_data : dec_dst;
  assign fwd_src = (res_valid && res_addr == dec_src_addr) ? res_data : dec_src;

  assign alu_exec = dec_valid && !stall &&
                    (insn_class == CLASS_ALU32 || insn_class == CLASS_ALU64);

  alu_core u_alu_core (
    .insn_class (insn_class),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .op_a       (fwd_dst),
    .op_b       (fwd_src),
    .imm        (dec_imm),
    .alu_result (alu_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      rf_we     <= 1'b0;
    end else begin
      rf_we <= alu_exec; // One pulse per executed instruction.
      if (alu_exec) begin
        res_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_exec) begin
      res_data <= alu_result;
      res_addr <= dec_dst_addr;
    end
  end

  assign rf_addr = res_addr;
  assign rf_data = res_data;

  // No writeback may come out of a cycle where a store holds the bus.
  a_no_wb_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !rf_we);

endmodule

`default_nettype wire

// ==== source/store_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_master #(
  parameter int ADDR_W = 32
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       dec_valid,
  input  ebpf_exe_pkg::insn_class_e  insn_class,
  input  ebpf_exe_pkg::store_size_e  store_size,
  input  ebpf_exe_pkg::xlen_t        fwd_dst,
  input  ebpf_exe_pkg::xlen_t        fwd_src,
  input  ebpf_exe_pkg::offset_t      dec_offset,
  input  logic                       bus_ack,
  output logic                       stall,
  output logic                       bus_cyc,
  output logic                       bus_stb,
  output logic                       bus_we,
  output logic [ADDR_W-1:0]          bus_adr,
  output ebpf_exe_pkg::byte_sel_t    bus_sel,
  output ebpf_exe_pkg::xlen_t        bus_dat_w
);

  import ebpf_exe_pkg::*;

  bus_state_e state;
  xlen_t      eff_addr;
  logic [2:0] lane;
  logic [2:0] align_mask;
  byte_sel_t  size_sel;
  xlen_t      data_mask;
  logic       store_exec;

  assign eff_addr = fwd_dst + {{48{dec_offset[15]}}, dec_offset}; // Signed offset.
  assign lane     = eff_addr[2:0];

  always_comb begin
    case (store_size)
      SIZE_B: begin
        size_sel   = 8'h01;
        data_mask  = 64'h0000_0000_0000_00ff;
        align_mask = 3'b000;
      end
      SIZE_H: begin
        size_sel   = 8'h03;
        data_mask  = 64'h0000_0000_0000_ffff;
        align_mask = 3'b001;
      end
      SIZE_W: begin
        size_sel   = 8'h0f;
        data_mask  = 64'h0000_0000_ffff_ffff;
        align_mask = 3'b011;
      end
      default: begin
        size_sel   = 8'hff;
        data_mask  = 64'hffff_ffff_ffff_ffff;
        align_mask = 3'b111;
      end
    endcase
  end

  assign store_exec = dec_valid && insn_class == CLASS_STX && state == BUS_IDLE;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= BUS_IDLE;
    end else begin
      case (state)
        BUS_IDLE: if (store_exec) state <= BUS_WAIT;
        BUS_WAIT: if (bus_ack) state <= BUS_IDLE;
        default:  state <= BUS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (store_exec) begin
      bus_adr   <= eff_addr[ADDR_W+2:3]; // Doubleword address.
      bus_sel   <= size_sel << lane;
      bus_dat_w <= (fwd_src & data_mask) << {lane, 3'b000};
    end
  end

  assign bus_cyc = (state == BUS_WAIT);
  assign bus_stb = bus_cyc;
  assign bus_we  = bus_cyc;
  assign stall   = bus_cyc;

  // Single beat write held unchanged until the slave answers.
  a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    bus_cyc && !bus_ack |=> bus_cyc && bus_stb && bus_we &&
    $stable(bus_adr) && $stable(bus_sel) && $stable(bus_dat_w));

  a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    store_exec |-> (lane & align_mask) == 3'b000);

endmodule

`default_nettype wire

// ==== source/ebpf_exe.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebpf_exe #(
  parameter int ADDR_W = 32
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     issue_valid,
  output logic                     issue_ready,
  input  ebpf_exe_pkg::opcode_t    opcode,
  input  ebpf_exe_pkg::reg_addr_t  dst_addr,
  input  ebpf_exe_pkg::reg_addr_t  src_addr,
  input  ebpf_exe_pkg::xlen_t      dst_operand,
  input  ebpf_exe_pkg::xlen_t      src_operand,
  input  ebpf_exe_pkg::imm_t       imm,
  input  ebpf_exe_pkg::offset_t    offset,
  output logic                     rf_we,
  output ebpf_exe_pkg::reg_addr_t  rf_addr,
  output ebpf_exe_pkg::xlen_t      rf_data,
  output logic                     bus_cyc,
  output logic                     bus_stb,
  output logic                     bus_we,
  output logic [ADDR_W-1:0]        bus_adr,
  output ebpf_exe_pkg::byte_sel_t  bus_sel,
  output ebpf_exe_pkg::xlen_t      bus_dat_w,
  input  logic                     bus_ack
);

  import ebpf_exe_pkg::*;

  logic        stall;
  logic        dec_valid;
  insn_class_e insn_class;
  alu_op_e     alu_op;
  logic        use_imm;
  store_size_e store_size;
  reg_addr_t   dec_dst_addr;
  reg_addr_t   dec_src_addr;
  xlen_t       dec_dst;
  xlen_t       dec_src;
  imm_t        dec_imm;
  offset_t     dec_offset;
  xlen_t       fwd_dst;
  xlen_t       fwd_src;

  insn_decoder u_insn_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .opcode       (opcode),
    .dst_addr     (dst_addr),
    .src_addr     (src_addr),
    .dst_operand  (dst_operand),
    .src_operand  (src_operand),
    .imm          (imm),
    .offset       (offset),
    .stall        (stall),
    .dec_valid    (dec_valid),
    .insn_class   (insn_class),
    .alu_op       (alu_op),
    .use_imm      (use_imm),
    .store_size   (store_size),
    .dec_dst_addr (dec_dst_addr),
    .dec_src_addr (dec_src_addr),
    .dec_dst      (dec_dst),
    .dec_src      (dec_src),
    .dec_imm      (dec_imm),
    .dec_offset   (dec_offset)
  );

  operand_forward u_operand_forward (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid    (dec_valid),
    .insn_class   (insn_class),
    .alu_op       (alu_op),
    .use_imm      (use_imm),
    .dec_imm      (dec_imm),
    .dec_dst_addr (dec_dst_addr),
    .dec_src_addr (dec_src_addr),
    .dec_dst      (dec_dst),
    .dec_src      (dec_src),
    .stall        (stall),
    .fwd_dst      (fwd_dst),
    .fwd_src      (fwd_src),
    .rf_we        (rf_we),
    .rf_addr      (rf_addr),
    .rf_data      (rf_data)
  );

  store_master #(
    .ADDR_W (ADDR_W)
  ) u_store_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec_valid  (dec_valid),
    .insn_class (insn_class),
    .store_size (store_size),
    .fwd_dst    (fwd_dst),
    .fwd_src    (fwd_src),
    .dec_offset (dec_offset),
    .bus_ack    (bus_ack),
    .stall      (stall),
    .bus_cyc    (bus_cyc),
    .bus_stb    (bus_stb),
    .bus_we     (bus_we),
    .bus_adr    (bus_adr),
    .bus_sel    (bus_sel),
    .bus_dat_w  (bus_dat_w)
  );

endmodule

`default_nettype wire

// ==== test/tb_ebpf_exe_checks.svh ====
// Reference model of the eBPF ALU operations.
function automatic xlen_t ref_alu(input opcode_t op, input xlen_t a, input xlen_t b,
                                  input imm_t k);
  xlen_t       y;
  xlen_t       r;
  logic [31:0] lo;
  logic [5:0]  sh;
  logic        w32;
  w32 = (op[2:0] == CLASS_ALU32);
  y   = op[SRC_REG_BIT] ? b : {32'h0, k};
  lo  = a[31:0];
  if (w32) begin
    a  = {32'h0, a[31:0]};
    y  = {32'h0, y[31:0]};
    sh = {1'b0, y[4:0]};
  end else begin
    sh = y[5:0];
  end
  case (op[7:4])
    ALU_ADD:  r = a + y;
    ALU_SUB:  r = a - y;
    ALU_OR:   r = a | y;
    ALU_AND:  r = a & y;
    ALU_LSH:  r = a << sh;
    ALU_RSH:  r = a >> sh;
    ALU_NEG:  r = -a;
    ALU_XOR:  r = a ^ y;
    ALU_MOV:  r = y;
    ALU_ARSH: begin
      if (w32) r = {32'h0, 32'($signed(lo) >>> sh)}; // Sign taken from bit 31.
      else r = $signed(a) >>> sh;
    end
    default:  r = a;
  endcase
  if (w32) r = {32'h0, r[31:0]};
  return r;
endfunction

function automatic int size_bytes(input logic [1:0] sz);
  case (sz)
    2'h0:    return 4;
    2'h1:    return 2;
    2'h2:    return 1;
    default: return 8;
  endcase
endfunction

// Every writeback must match the oldest outstanding ALU result.
a_wb_value: assert property (@(posedge clk) disable iff (!rst_n)
  rf_we |-> chk_we_valid && rf_addr == chk_addr && rf_data == chk_data)
  else value_error($sformatf("writeback r%0d = %h, expected r%0d = %h",
                             rf_addr, rf_data, chk_addr, chk_data));

a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
  rf_we |-> chk_lat_ok)
  else value_error("writeback not 2 cycles after acceptance");

a_store_fields: assert property (@(posedge clk) disable iff (!rst_n)
  bus_cyc |-> st_head_valid && bus_stb && bus_we && bus_adr == st_head_adr &&
              bus_sel == st_head_sel && bus_dat_w == st_head_dat)
  else value_error($sformatf("store adr %h sel %h dat %h, expected %h %h %h",
                             bus_adr, bus_sel, bus_dat_w,
                             st_head_adr, st_head_sel, st_head_dat));

a_store_stall: assert property (@(posedge clk) disable iff (!rst_n)
  bus_cyc |-> !issue_ready && !rf_we)
  else value_error("issue accepted or writeback seen during a bus cycle");

a_cycle_held: assert property (@(posedge clk) disable iff (!rst_n)
  bus_cyc && !bus_ack |=> bus_cyc)
  else value_error("bus cycle dropped before ack");

// ==== test/tb_ebpf_exe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ebpf_exe;

  import ebpf_exe_pkg::*;

  localparam int        ADDR_W    = 32;
  localparam int        MEM_DEPTH = 64;
  localparam reg_addr_t BASE_REG  = 4'd10;

  logic               clk;
  logic               rst_n;
  logic               issue_valid;
  logic               issue_ready;
  opcode_t            opcode;
  reg_addr_t          dst_addr;
  reg_addr_t          src_addr;
  xlen_t              dst_operand;
  xlen_t              src_operand;
  imm_t               imm;
  offset_t            offset;
  logic               rf_we;
  reg_addr_t          rf_addr;
  xlen_t              rf_data;
  logic               bus_cyc;
  logic               bus_stb;
  logic               bus_we;
  logic [ADDR_W-1:0]  bus_adr;
  byte_sel_t          bus_sel;
  xlen_t              bus_dat_w;
  logic               bus_ack;

  xlen_t rf [16];   // As written back by the DUT.
  xlen_t arch [16]; // In program order.
  xlen_t mem [MEM_DEPTH];
  xlen_t exp_mem [MEM_DEPTH];

  logic [67:0]       wb_q [$];
  int                wb_acc_q [$];
  bit                wb_skip_q [$];
  logic [ADDR_W-1:0] st_adr_q [$];
  byte_sel_t         st_sel_q [$];
  xlen_t             st_dat_q [$];

  logic              chk_we_valid;
  logic              chk_lat_ok;
  reg_addr_t         chk_addr;
  xlen_t             chk_data;
  logic              st_head_valid;
  logic [ADDR_W-1:0] st_head_adr;
  byte_sel_t         st_head_sel;
  xlen_t             st_head_dat;
  int                cycle_cnt = 0;
  bit                prev_store;
  bit                bus_open;
  int                wait_left;

  ebpf_exe #(.ADDR_W(ADDR_W)) u_ebpf_exe (
    .clk (clk), .rst_n (rst_n),
    .issue_valid (issue_valid), .issue_ready (issue_ready), .opcode (opcode),
    .dst_addr (dst_addr), .src_addr (src_addr),
    .dst_operand (dst_operand), .src_operand (src_operand),
    .imm (imm), .offset (offset),
    .rf_we (rf_we), .rf_addr (rf_addr), .rf_data (rf_data),
    .bus_cyc (bus_cyc), .bus_stb (bus_stb), .bus_we (bus_we), .bus_adr (bus_adr),
    .bus_sel (bus_sel), .bus_dat_w (bus_dat_w), .bus_ack (bus_ack)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic stop_failed(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic value_error(input string msg);
    stop_failed($sformatf("Fail %0t: %s", $time, msg));
  endtask

  // Register file writes first, then the memory slave, then the head of the store queue.
  task automatic service_models();
    int lat;
    if (rf_we) begin
      rf[rf_addr]  = rf_data;
      chk_we_valid = (wb_q.size() != 0);
      if (chk_we_valid) begin
        {chk_addr, chk_data} = wb_q.pop_front();
        lat        = cycle_cnt - wb_acc_q.pop_front();
        chk_lat_ok = wb_skip_q.pop_front() || lat == 2;
      end
    end else begin
      chk_we_valid = 1'b0;
    end
    if (bus_ack) begin
      bus_ack = 1'b0;
      st_adr_q.delete(0);
      st_sel_q.delete(0);
      st_dat_q.delete(0);
    end else if (bus_cyc) begin
      if (!bus_open) begin
        bus_open  = 1'b1;
        wait_left = $urandom_range(3, 0);
      end
      if (wait_left == 0) begin
        for (int i = 0; i < 8; i++) begin
          if (bus_sel[i]) mem[bus_adr[5:0]][8*i +: 8] = bus_dat_w[8*i +: 8];
        end
        bus_ack  = 1'b1;
        bus_open = 1'b0;
      end else begin
        wait_left--;
      end
    end
    st_head_valid = (st_adr_q.size() != 0);
    if (st_head_valid) begin
      st_head_adr = st_adr_q[0];
      st_head_sel = st_sel_q[0];
      st_head_dat = st_dat_q[0];
    end
  endtask

  task automatic tick();
    @(negedge clk);
    service_models();
    issue_valid = 1'b0;
  endtask

  task automatic record_expected(input opcode_t op, input reg_addr_t d, input reg_addr_t s,
                                 input imm_t iv, input offset_t ov);
    xlen_t      res;
    xlen_t      ea;
    xlen_t      dat;
    byte_sel_t  sel;
    int         nb;
    logic [2:0] lane;
    if (op[2:0] == CLASS_STX) begin
      ea   = arch[d] + {{48{ov[15]}}, ov};
      nb   = size_bytes(op[4:3]);
      lane = ea[2:0];
      dat  = '0;
      sel  = '0;
      for (int i = 0; i < nb; i++) begin
        sel[lane+i]                       = 1'b1;
        dat[8*(lane+i) +: 8]              = arch[s][8*i +: 8];
        exp_mem[ea[8:3]][8*(lane+i) +: 8] = arch[s][8*i +: 8];
      end
      st_adr_q.push_back(ea[ADDR_W+2:3]);
      st_sel_q.push_back(sel);
      st_dat_q.push_back(dat);
    end else begin
      res     = ref_alu(op, arch[d], arch[s], iv);
      arch[d] = res;
      wb_q.push_back({d, res});
      wb_acc_q.push_back(cycle_cnt);
      wb_skip_q.push_back(prev_store); // Waits behind the store's bus cycle.
    end
    prev_store = (op[2:0] == CLASS_STX);
  endtask

  task automatic issue_insn(input opcode_t op, input reg_addr_t d, input reg_addr_t s,
                            input imm_t iv, input offset_t ov);
    int waited;
    bit done;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      tick();
      issue_valid = 1'b1;
      opcode      = op;
      dst_addr    = d;
      src_addr    = s;
      dst_operand = rf[d]; // Possibly stale.
      src_operand = rf[s];
      imm         = iv;
      offset      = ov;
      if (issue_ready) begin
        done = 1'b1;
        record_expected(op, d, s, iv, ov);
      end else begin
        waited++;
        if (waited > 20) stop_failed("Timed out waiting for issue_ready");
      end
    end
  endtask

  initial begin
    int          waited;
    reg_addr_t   d;
    opcode_t     op;
    alu_op_e     ops [10];
    ops = '{ALU_ADD, ALU_SUB, ALU_OR, ALU_AND, ALU_LSH,
            ALU_RSH, ALU_NEG, ALU_XOR, ALU_MOV, ALU_ARSH};
    void'($urandom(32'ha6d9));
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    opcode      = '0;
    dst_addr    = '0;
    src_addr    = '0;
    dst_operand = '0;
    src_operand = '0;
    imm         = '0;
    offset      = '0;
    bus_ack     = 1'b0;
    prev_store  = 1'b0;
    bus_open    = 1'b0;
    wait_left   = 0;
    for (int i = 0; i < 16; i++) begin
      rf[i]   = '0;
      arch[i] = '0;
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i]     = {i * 32'h9e37_79b9, ~i}; // Unique per word.
      exp_mem[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    tick();
    assert (!rf_we && !bus_cyc && !bus_stb && !bus_we && issue_ready)
      else value_error("outputs not idle after reset");

    for (int r = 1; r < 10; r++) issue_insn(8'hb7, reg_addr_t'(r), 4'd0, $urandom(), 16'h0);
    issue_insn(8'h67, 4'd1, 4'd0, 32'd32, 16'h0);
    issue_insn(8'h4f, 4'd1, 4'd2, 32'd0, 16'h0);
    issue_insn(8'hb4, 4'd9, 4'd0, 32'h8000_0f00, 16'h0);
    issue_insn(8'hc4, 4'd9, 4'd0, 32'd36, 16'h0); // Shift 36 masks to 4.
    issue_insn(8'hb7, BASE_REG, 4'd0, 32'd64, 16'h0);

    // Each op is followed by an add that reads its result.
    for (int i = 0; i < 10; i++) begin
      for (int c = 0; c < 2; c++) begin
        for (int x = 0; x < 2; x++) begin
          d  = reg_addr_t'(1 + $urandom_range(7));
          op = {ops[i], x[0], (c == 0) ? 3'h4 : 3'h7};
          issue_insn(op, d, reg_addr_t'(1 + $urandom_range(8)), $urandom(), 16'h0);
          issue_insn(8'h0f, reg_addr_t'(1 + $urandom_range(7)), d, 32'd0, 16'h0);
        end
      end
    end

    for (int sz = 0; sz < 4; sz++) begin
      for (int k = 0; k < 4; k++) begin
        op = {3'b011, sz[1:0], 3'b011};
        issue_insn(op, BASE_REG, reg_addr_t'(1 + $urandom_range(8)), 32'd0,
                   offset_t'(size_bytes(sz[1:0]) * $urandom_range(15)));
        issue_insn(8'h07, reg_addr_t'(1 + $urandom_range(7)), 4'd0, $urandom(), 16'h0);
      end
    end

    waited = 0;
    while (wb_q.size() != 0 || st_adr_q.size() != 0 || bus_cyc) begin
      tick();
      waited++;
      if (waited > 100) stop_failed("Timed out waiting for the pipeline to drain");
    end
    repeat (3) tick();
    for (int i = 0; i < MEM_DEPTH; i++) begin
      assert (mem[i] == exp_mem[i])
        else value_error($sformatf("memory word %0d is %h, expected %h", i, mem[i], exp_mem[i]));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  `include "tb_ebpf_exe_checks.svh"

endmodule

`default_nettype wire

// ==== ebpf_exe.f ====
+incdir+test
source/ebpf_exe_pkg.sv
source/insn_decoder.sv
source/alu_core.sv
source/operand_forward.sv
source/store_master.sv
source/ebpf_exe.sv
test/tb_ebpf_exe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_ebpf_exe \
  -f ebpf_exe.f

./obj_dir/Vtb_ebpf_exe 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
